/* Bender.yml */
package:
  name: cpuTop

sources:
  - hdl/cpuPkg.sv
  - hdl/hazardIf.sv
  - hdl/hazardUnit.sv
  - hdl/regFile.sv
  - hdl/syncRam.sv
  - hdl/cpuPipeline.sv
  - hdl/hostRegs.sv
  - hdl/cpuTop.sv
  - target: test
    files:
      - test/cpuTop_assert.sv
      - test/cpuTop_tb.sv

/* cpuTop.f */
hdl/cpuPkg.sv
hdl/hazardIf.sv
hdl/hazardUnit.sv
hdl/regFile.sv
hdl/syncRam.sv
hdl/cpuPipeline.sv
hdl/hostRegs.sv
hdl/cpuTop.sv
test/cpuTop_assert.sv
test/cpuTop_tb.sv

/* hdl/cpuPipeline.sv */
`default_nettype none

module cpuPipeline #(
	parameter int IMEM_WORDS = 256,
	parameter int DMEM_WORDS = 256
) (
	input logic clk,
	input logic rstN,
	input logic run,
	output logic halted,
	output logic retirePulse,
	// instruction memory
	output logic [$clog2(IMEM_WORDS)-1:0] imemAddr,
	input cpuPkg::word_t imemData,
	// data memory
	output logic [$clog2(DMEM_WORDS)-1:0] dmemAddr,
	output logic dmemWe,
	output cpuPkg::word_t dmemWData,
	input cpuPkg::word_t dmemRData,
	// register file
	output cpuPkg::regIdx_t rfRAddr1,
	output cpuPkg::regIdx_t rfRAddr2,
	output cpuPkg::regIdx_t rfWAddr,
	output logic rfWe,
	output cpuPkg::word_t rfWData,
	input cpuPkg::word_t rfRData1,
	input cpuPkg::word_t rfRData2,
	hazardIf.pipe hz
);

	localparam int IAW = $clog2(IMEM_WORDS);
	localparam int DAW = $clog2(DMEM_WORDS);

	// run edge and advance
	logic runQ, start, adv, fetchStop;
	// fetch
	cpuPkg::word_t pcF, pcPlus4F;
	// decode
	logic validD, isRtypeD, haltD, takeD;
	logic regWriteD, memToRegD, memWriteD, aluSrcD;
	cpuPkg::word_t instrD, pcPlus4D, immD, srcAD, srcBD, branchTargetD;
	cpuPkg::opcode_t opD;
	cpuPkg::regIdx_t rsD, rtD, writeRegD;
	cpuPkg::funct_t aluFnD;
	// execute
	logic validE, regWriteE, memToRegE, memWriteE, aluSrcE, haltE;
	cpuPkg::regIdx_t rsE, rtE, writeRegE;
	cpuPkg::funct_t aluFnE;
	cpuPkg::word_t immE, rdAE, rdBE, srcAE, srcBRegE, srcBE, aluOutE;
	// memory
	logic validM, regWriteM, memToRegM, memWriteM, haltM;
	cpuPkg::regIdx_t writeRegM;
	cpuPkg::word_t aluOutM, writeDataM;
	// writeback
	logic validW, regWriteW, memToRegW, haltW;
	cpuPkg::regIdx_t writeRegW;
	cpuPkg::word_t aluOutW, readDataW, resultW;

	// first cycle after run rises restarts the core
	always_ff @(posedge clk) begin
		if (!rstN) begin
			runQ <= 1'b0;
		end else begin
			runQ <= run;
		end
	end
	assign start = run && !runQ;
	// run low freezes every stage
	assign adv = run && runQ;

	//////////////////////////////
	// fetch
	//////////////////////////////
	assign pcPlus4F = pcF + 32'd4;
	assign imemAddr = pcF[2 +: IAW];

	//////////////////////////////
	// decode
	//////////////////////////////
	assign opD = instrD[31:26];
	assign rsD = instrD[25:21];
	assign rtD = instrD[20:16];
	assign immD = {{16{instrD[15]}}, instrD[15:0]};
	assign isRtypeD = opD == cpuPkg::OP_RTYPE;
	assign haltD = validD && opD == cpuPkg::OP_HALT;

	// control, qualified by valid later
	assign regWriteD = isRtypeD || opD == cpuPkg::OP_ADDI || opD == cpuPkg::OP_LW;
	assign memToRegD = opD == cpuPkg::OP_LW;
	assign memWriteD = opD == cpuPkg::OP_SW;
	assign aluSrcD = !isRtypeD;
	assign writeRegD = isRtypeD ? instrD[15:11] : rtD;
	// immediate forms all add
	assign aluFnD = isRtypeD ? instrD[5:0] : cpuPkg::FN_ADD;

	assign rfRAddr1 = rsD;
	assign rfRAddr2 = rtD;

	// branch compare, memory stage bypass only
	assign srcAD = hz.forwardAD ? aluOutM : rfRData1;
	assign srcBD = hz.forwardBD ? aluOutM : rfRData2;
	assign takeD = hz.branchD && srcAD == srcBD;
	// offset is relative to the delay slot
	assign branchTargetD = pcPlus4D + {immD[29:0], 2'b00};

	//////////////////////////////
	// execute
	//////////////////////////////
	always_comb begin
		case (hz.forwardAE)
			cpuPkg::FWD_MEM: srcAE = aluOutM;
			cpuPkg::FWD_WB: srcAE = resultW;
			default: srcAE = rdAE;
		endcase
		case (hz.forwardBE)
			cpuPkg::FWD_MEM: srcBRegE = aluOutM;
			cpuPkg::FWD_WB: srcBRegE = resultW;
			default: srcBRegE = rdBE;
		endcase
	end
	assign srcBE = aluSrcE ? immE : srcBRegE;

	always_comb begin
		case (aluFnE)
			cpuPkg::FN_SUB: aluOutE = srcAE - srcBE;
			cpuPkg::FN_AND: aluOutE = srcAE & srcBE;
			cpuPkg::FN_OR: aluOutE = srcAE | srcBE;
			cpuPkg::FN_SLT: aluOutE = {31'b0, $signed(srcAE) < $signed(srcBE)};
			default: aluOutE = srcAE + srcBE;
		endcase
	end

	//////////////////////////////
	// memory and writeback
	//////////////////////////////
	assign dmemAddr = aluOutM[2 +: DAW];
	assign dmemWe = adv && validM && memWriteM;
	assign dmemWData = writeDataM;

	assign resultW = memToRegW ? readDataW : aluOutW;
	assign rfWAddr = writeRegW;
	assign rfWe = adv && validW && regWriteW;
	assign rfWData = resultW;
	// one pulse per instruction leaving writeback, halt included
	assign retirePulse = adv && validW;

	// hazard unit view
	assign hz.rsD = rsD;
	assign hz.rtD = rtD;
	assign hz.branchD = validD && opD == cpuPkg::OP_BEQ;
	assign hz.rsE = rsE;
	assign hz.rtE = rtE;
	assign hz.writeRegE = writeRegE;
	assign hz.regWriteE = validE && regWriteE;
	assign hz.memToRegE = validE && memToRegE;
	assign hz.writeRegM = writeRegM;
	assign hz.regWriteM = validM && regWriteM;
	assign hz.memToRegM = validM && memToRegM;
	assign hz.writeRegW = writeRegW;
	assign hz.regWriteW = validW && regWriteW;

	// pc, valids and halt tracking
	always_ff @(posedge clk) begin
		if (!rstN || start) begin
			pcF <= '0;
			validD <= 1'b0;
			validE <= 1'b0;
			validM <= 1'b0;
			validW <= 1'b0;
			fetchStop <= 1'b0;
			halted <= 1'b0;
		end else if (adv) begin
			if (!hz.stallF && !fetchStop) begin
				pcF <= takeD ? branchTargetD : pcPlus4F;
			end
			// nothing behind a halt enters decode
			if (!hz.stallD) begin
				validD <= !fetchStop && !haltD;
				if (haltD) begin
					fetchStop <= 1'b1;
				end
			end
			validE <= validD && !hz.flushE;
			validM <= validE;
			validW <= validM;
			if (validW && haltW) begin
				halted <= 1'b1;
			end
		end
	end

	// stage payload, gated by the valids above
	always_ff @(posedge clk) begin
		if (adv) begin
			if (!hz.stallD) begin
				instrD <= imemData;
				pcPlus4D <= pcPlus4F;
			end
			// d/e
			rsE <= rsD;
			rtE <= rtD;
			writeRegE <= writeRegD;
			regWriteE <= regWriteD;
			memToRegE <= memToRegD;
			memWriteE <= memWriteD;
			aluSrcE <= aluSrcD;
			aluFnE <= aluFnD;
			immE <= immD;
			rdAE <= rfRData1;
			rdBE <= rfRData2;
			haltE <= haltD;
			// e/m
			aluOutM <= aluOutE;
			writeDataM <= srcBRegE;
			writeRegM <= writeRegE;
			regWriteM <= regWriteE;
			memToRegM <= memToRegE;
			memWriteM <= memWriteE;
			haltM <= haltE;
			// m/w
			aluOutW <= aluOutM;
			readDataW <= dmemRData;
			writeRegW <= writeRegM;
			regWriteW <= regWriteM;
			memToRegW <= memToRegM;
			haltW <= haltM;
		end
	end

endmodule

`default_nettype wire

/* hdl/cpuPkg.sv */
`default_nettype none

package cpuPkg;

	// datapath word and register number
	typedef logic [31:0] word_t;
	typedef logic [4:0] regIdx_t;
	// apb byte address
	typedef logic [11:0] apbAddr_t;

	//////////////////////////////
	// instruction encodings
	//////////////////////////////

	// primary opcodes, mips numbering
	typedef logic [5:0] opcode_t;
	localparam opcode_t OP_RTYPE = 6'h00;
	localparam opcode_t OP_BEQ = 6'h04;
	localparam opcode_t OP_ADDI = 6'h08;
	localparam opcode_t OP_LW = 6'h23;
	localparam opcode_t OP_SW = 6'h2b;
	// all ones stops the core
	localparam opcode_t OP_HALT = 6'h3f;

	// r-type function field
	typedef logic [5:0] funct_t;
	localparam funct_t FN_ADD = 6'h20;
	localparam funct_t FN_SUB = 6'h22;
	localparam funct_t FN_AND = 6'h24;
	localparam funct_t FN_OR = 6'h25;
	localparam funct_t FN_SLT = 6'h2a;

	// execute operand source
	typedef enum logic [1:0] {
		FWD_NONE = 2'b00,
		FWD_MEM  = 2'b01,
		FWD_WB   = 2'b10
	} fwdSel_t;

	//////////////////////////////
	// host register map
	//////////////////////////////
	localparam apbAddr_t ADDR_CTRL = 12'h000;
	localparam apbAddr_t ADDR_STATUS = 12'h004;
	localparam apbAddr_t ADDR_RETIRED = 12'h008;
	// 32 words, one per register
	localparam apbAddr_t REG_BASE = 12'h080;
	localparam apbAddr_t IMEM_BASE = 12'h400;
	localparam apbAddr_t DMEM_BASE = 12'h800;

endpackage

`default_nettype wire

/* hdl/cpuTop.sv */
`default_nettype none

module cpuTop #(
	parameter int IMEM_WORDS = 256,
	parameter int DMEM_WORDS = 256
) (
	input logic clk,
	input logic rstN,
	// apb slave
	input logic pSel,
	input logic pEnable,
	input logic pWrite,
	input cpuPkg::apbAddr_t pAddr,
	input cpuPkg::word_t pWData,
	output cpuPkg::word_t pRData,
	output logic pReady,
	output logic pSlvErr
);

	localparam int IAW = $clog2(IMEM_WORDS);
	localparam int DAW = $clog2(DMEM_WORDS);

	// core control
	logic run, halted, retirePulse;
	// pipeline memory ports
	logic [IAW-1:0] pipeImemAddr;
	logic [DAW-1:0] pipeDmemAddr;
	logic pipeDmemWe;
	cpuPkg::word_t imemData, pipeDmemWData, pipeDmemRData;
	// register file
	cpuPkg::regIdx_t rfRAddr1, rfRAddr2, rfWAddr, hostRegAddr;
	logic rfWe;
	cpuPkg::word_t rfWData, rfRData1, rfRData2, hostRegData;
	// host memory ports
	logic [IAW-1:0] hostImemAddr;
	logic [DAW-1:0] hostDmemAddr;
	logic hostImemWe, hostDmemWe;
	cpuPkg::word_t hostImemWData, hostImemRData, hostDmemWData, hostDmemRData;

	hazardIf hzIf ();

	hazardUnit hazard_i (.hz(hzIf.hazard));

	regFile regFile_i (
		.clk(clk), .rstN(rstN),
		.raddr1(rfRAddr1), .raddr2(rfRAddr2), .hostAddr(hostRegAddr),
		.waddr(rfWAddr), .we(rfWe), .wdata(rfWData),
		.rdata1(rfRData1), .rdata2(rfRData2), .hostData(hostRegData)
	);

	// pipeline never writes instructions
	syncRam #(.WORDS(IMEM_WORDS)) imemRam (
		.clk(clk),
		.aAddr(pipeImemAddr), .aWe(1'b0), .aWData('0), .aRData(imemData),
		.bAddr(hostImemAddr), .bWe(hostImemWe), .bWData(hostImemWData),
		.bRData(hostImemRData)
	);

	syncRam #(.WORDS(DMEM_WORDS)) dmemRam (
		.clk(clk),
		.aAddr(pipeDmemAddr), .aWe(pipeDmemWe), .aWData(pipeDmemWData),
		.aRData(pipeDmemRData),
		.bAddr(hostDmemAddr), .bWe(hostDmemWe), .bWData(hostDmemWData),
		.bRData(hostDmemRData)
	);

	cpuPipeline #(.IMEM_WORDS(IMEM_WORDS), .DMEM_WORDS(DMEM_WORDS)) pipeline_i (
		.clk(clk), .rstN(rstN), .run(run), .halted(halted), .retirePulse(retirePulse),
		.imemAddr(pipeImemAddr), .imemData(imemData),
		.dmemAddr(pipeDmemAddr), .dmemWe(pipeDmemWe), .dmemWData(pipeDmemWData),
		.dmemRData(pipeDmemRData),
		.rfRAddr1(rfRAddr1), .rfRAddr2(rfRAddr2), .rfWAddr(rfWAddr), .rfWe(rfWe),
		.rfWData(rfWData), .rfRData1(rfRData1), .rfRData2(rfRData2),
		.hz(hzIf.pipe)
	);

	hostRegs #(.IMEM_WORDS(IMEM_WORDS), .DMEM_WORDS(DMEM_WORDS)) hostRegs_i (
		.clk(clk), .rstN(rstN),
		.pSel(pSel), .pEnable(pEnable), .pWrite(pWrite), .pAddr(pAddr),
		.pWData(pWData), .pRData(pRData), .pReady(pReady), .pSlvErr(pSlvErr),
		.run(run), .halted(halted), .retirePulse(retirePulse),
		.regAddr(hostRegAddr), .regData(hostRegData),
		.imemAddr(hostImemAddr), .imemWe(hostImemWe), .imemWData(hostImemWData),
		.imemRData(hostImemRData),
		.dmemAddr(hostDmemAddr), .dmemWe(hostDmemWe), .dmemWData(hostDmemWData),
		.dmemRData(hostDmemRData)
	);

endmodule

`default_nettype wire

/* hdl/hazardIf.sv */
`default_nettype none

interface hazardIf;
	// decode stage
	cpuPkg::regIdx_t rsD, rtD;
	logic branchD;
	logic forwardAD, forwardBD;
	logic stallF, stallD;
	// execute stage
	cpuPkg::regIdx_t rsE, rtE, writeRegE;
	logic regWriteE, memToRegE;
	cpuPkg::fwdSel_t forwardAE, forwardBE;
	logic flushE;
	// memory and writeback stages
	cpuPkg::regIdx_t writeRegM, writeRegW;
	logic regWriteM, memToRegM, regWriteW;

	// write enables arrive already qualified by stage valid
	modport pipe (
		output rsD, rtD, branchD, rsE, rtE, writeRegE, regWriteE, memToRegE,
		output writeRegM, regWriteM, memToRegM, writeRegW, regWriteW,
		input forwardAD, forwardBD, forwardAE, forwardBE, stallF, stallD, flushE
	);

	modport hazard (
		input rsD, rtD, branchD, rsE, rtE, writeRegE, regWriteE, memToRegE,
		input writeRegM, regWriteM, memToRegM, writeRegW, regWriteW,
		output forwardAD, forwardBD, forwardAE, forwardBE, stallF, stallD, flushE
	);
endinterface

`default_nettype wire

/* hdl/hazardUnit.sv */
`default_nettype none

module hazardUnit (
	hazardIf.hazard hz
);

	logic lwStall;
	logic branchStall;
	logic branchSrcE;
	logic branchSrcM;

	// execute operand source for one register number
	// memory stage is younger, so it wins over writeback
	function automatic cpuPkg::fwdSel_t fwdSel(input cpuPkg::regIdx_t src);
		if (src != '0 && hz.regWriteM && src == hz.writeRegM) begin
			return cpuPkg::FWD_MEM;
		end else if (src != '0 && hz.regWriteW && src == hz.writeRegW) begin
			return cpuPkg::FWD_WB;
		end
		return cpuPkg::FWD_NONE;
	endfunction

	//////////////////////////////
	// forwarding
	//////////////////////////////

	// decode branch compare, memory stage only
	// writeback reaches decode through the register file bypass
	assign hz.forwardAD = hz.rsD != '0 && hz.regWriteM && hz.rsD == hz.writeRegM;
	assign hz.forwardBD = hz.rtD != '0 && hz.regWriteM && hz.rtD == hz.writeRegM;

	// alu operands
	assign hz.forwardAE = fwdSel(hz.rsE);
	assign hz.forwardBE = fwdSel(hz.rtE);

	//////////////////////////////
	// stalls
	//////////////////////////////

	// load in execute feeding decode
	assign lwStall = hz.memToRegE && hz.writeRegE != '0 &&
		(hz.writeRegE == hz.rsD || hz.writeRegE == hz.rtD);

	// branch operand still in execute
	assign branchSrcE = hz.regWriteE && hz.writeRegE != '0 &&
		(hz.writeRegE == hz.rsD || hz.writeRegE == hz.rtD);
	// load data not back until writeback
	assign branchSrcM = hz.memToRegM && hz.writeRegM != '0 &&
		(hz.writeRegM == hz.rsD || hz.writeRegM == hz.rtD);
	assign branchStall = hz.branchD && (branchSrcE || branchSrcM);

	// hold fetch and decode, bubble into execute
	assign hz.stallD = lwStall || branchStall;
	assign hz.stallF = hz.stallD;
	assign hz.flushE = hz.stallD;

endmodule

`default_nettype wire

/* hdl/hostRegs.sv */
`default_nettype none

module hostRegs #(
	parameter int IMEM_WORDS = 256,
	parameter int DMEM_WORDS = 256
) (
	input logic clk,
	input logic rstN,
	// apb slave
	input logic pSel,
	input logic pEnable,
	input logic pWrite,
	input cpuPkg::apbAddr_t pAddr,
	input cpuPkg::word_t pWData,
	output cpuPkg::word_t pRData,
	output logic pReady,
	output logic pSlvErr,
	// core control
	output logic run,
	input logic halted,
	input logic retirePulse,
	// register file window
	output cpuPkg::regIdx_t regAddr,
	input cpuPkg::word_t regData,
	// instruction memory window
	output logic [$clog2(IMEM_WORDS)-1:0] imemAddr,
	output logic imemWe,
	output cpuPkg::word_t imemWData,
	input cpuPkg::word_t imemRData,
	// data memory window
	output logic [$clog2(DMEM_WORDS)-1:0] dmemAddr,
	output logic dmemWe,
	output cpuPkg::word_t dmemWData,
	input cpuPkg::word_t dmemRData
);

	localparam int IAW = $clog2(IMEM_WORDS);
	localparam int DAW = $clog2(DMEM_WORDS);

	logic access, imemSel, dmemSel, regSel;
	logic memRead, memWrite, ctrlWrite, waitDone;
	cpuPkg::word_t retired;

	//////////////////////////////
	// address decode
	//////////////////////////////
	assign access = pSel && pEnable;
	assign imemSel = pAddr[11:10] == cpuPkg::IMEM_BASE[11:10];
	assign dmemSel = pAddr[11:10] == cpuPkg::DMEM_BASE[11:10];
	assign regSel = pAddr[11:7] == cpuPkg::REG_BASE[11:7];
	assign memRead = access && !pWrite && (imemSel || dmemSel);
	assign memWrite = access && pWrite && (imemSel || dmemSel);
	assign ctrlWrite = access && pWrite && pAddr == cpuPkg::ADDR_CTRL;

	// word index, held stable by the master from setup on
	assign regAddr = pAddr[6:2];
	assign imemAddr = pAddr[2 +: IAW];
	assign dmemAddr = pAddr[2 +: DAW];
	assign imemWData = pWData;
	assign dmemWData = pWData;

	// memories are only writable while stopped
	assign imemWe = memWrite && imemSel && !run;
	assign dmemWe = memWrite && dmemSel && !run;
	assign pSlvErr = memWrite && run;

	// one wait state on memory reads
	assign pReady = !(memRead && !waitDone);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			waitDone <= 1'b0;
			run <= 1'b0;
			retired <= '0;
		end else begin
			waitDone <= memRead && !waitDone;
			if (ctrlWrite) begin
				run <= pWData[0];
			end
			// new run starts counting from zero
			if (ctrlWrite && pWData[0] && !run) begin
				retired <= '0;
			end else if (retirePulse) begin
				retired <= retired + 32'd1;
			end
		end
	end

	// read data
	always_comb begin
		pRData = '0;
		if (imemSel) begin
			pRData = imemRData;
		end else if (dmemSel) begin
			pRData = dmemRData;
		end else if (regSel) begin
			pRData = regData;
		end else if (pAddr == cpuPkg::ADDR_CTRL) begin
			pRData = {31'b0, run};
		end else if (pAddr == cpuPkg::ADDR_STATUS) begin
			pRData = {31'b0, halted};
		end else if (pAddr == cpuPkg::ADDR_RETIRED) begin
			pRData = retired;
		end
	end

endmodule

`default_nettype wire

/* hdl/regFile.sv */
`default_nettype none

module regFile (
	input logic clk,
	input logic rstN,
	input cpuPkg::regIdx_t raddr1,
	input cpuPkg::regIdx_t raddr2,
	input cpuPkg::regIdx_t hostAddr,
	input cpuPkg::regIdx_t waddr,
	input logic we,
	input cpuPkg::word_t wdata,
	output cpuPkg::word_t rdata1,
	output cpuPkg::word_t rdata2,
	output cpuPkg::word_t hostData
);

	cpuPkg::word_t regs [32];

	// register 0 is never written and stays at its reset value
	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// write-first, decode sees writeback of the same cycle
	assign rdata1 = (raddr1 == '0) ? '0 : (we && waddr == raddr1) ? wdata : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : (we && waddr == raddr2) ? wdata : regs[raddr2];

	// host window, plain read
	assign hostData = regs[hostAddr];

endmodule

`default_nettype wire

/* hdl/syncRam.sv */
`default_nettype none

module syncRam #(
	parameter int WORDS = 256
) (
	input logic clk,
	// pipeline port
	input logic [$clog2(WORDS)-1:0] aAddr,
	input logic aWe,
	input cpuPkg::word_t aWData,
	output cpuPkg::word_t aRData,
	// host port
	input logic [$clog2(WORDS)-1:0] bAddr,
	input logic bWe,
	input cpuPkg::word_t bWData,
	output cpuPkg::word_t bRData
);

	cpuPkg::word_t mem [WORDS];

	// both ports write, host read goes through a register
	always_ff @(posedge clk) begin
		if (aWe) begin
			mem[aAddr] <= aWData;
		end
		if (bWe) begin
			mem[bAddr] <= bWData;
		end
		bRData <= mem[bAddr];
	end

	// single cycle access for the pipeline
	assign aRData = mem[aAddr];

endmodule

`default_nettype wire

/* test/cpuTop_assert.sv */
`default_nettype none

module cpuTop_assert (
	input logic clk,
	input logic rstN,
	hazardIf hz,
	input logic run,
	input logic pReady,
	input cpuPkg::word_t pRData
);
	timeunit 1ns;
	timeprecision 1ps;

	//////////////////////////////
	// hazard unit
	//////////////////////////////

	// a held decode stage leaves a bubble in execute
	// start and frozen cycles excluded by run
	stallBubble: assert property (@(posedge clk) disable iff (!rstN)
		hz.stallD && run |=> !hz.regWriteE && !hz.memToRegE)
		else $error("decode stall let an instruction into execute");

	//////////////////////////////
	// apb side
	//////////////////////////////

	// read data seen in the wait state carries into completion
	rdataHeld: assert property (@(posedge clk) disable iff (!rstN)
		!pReady |=> $stable(pRData))
		else $error("read data changed across the wait state");

endmodule

// bound into the top to see the hazard interface, run and the apb outputs
bind cpuTop cpuTop_assert assert_i (
	.clk(clk),
	.rstN(rstN),
	.hz(hzIf),
	.run(run),
	.pReady(pReady),
	.pRData(pRData)
);

`default_nettype wire

/* test/cpuTop_tb.sv */
`default_nettype none

module cpuTop_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_PROGS = 6;
	localparam int PROG_LEN = 40;
	localparam int DATA_WORDS = 16;
	// bus traffic and run time of every program, plus reset
	localparam int CYCLE_LIMIT = NUM_PROGS * (PROG_LEN * 3 + 600) + 100;

	logic clk = 1'b0;
	logic rstN;
	logic pSel, pEnable, pWrite;
	cpuPkg::apbAddr_t pAddr;
	cpuPkg::word_t pWData, pRData;
	logic pReady, pSlvErr;

	integer seed = 32'h928c;
	int cycles = 0;
	int checks = 0;
	int errors = 0;
	// current program and reference state
	cpuPkg::word_t prog [PROG_LEN];
	cpuPkg::word_t modelRegs [32];
	cpuPkg::word_t modelMem [256];
	int modelCount;

	cpuTop cpuTop_i (
		.clk(clk), .rstN(rstN),
		.pSel(pSel), .pEnable(pEnable), .pWrite(pWrite), .pAddr(pAddr),
		.pWData(pWData), .pRData(pRData), .pReady(pReady), .pSlvErr(pSlvErr)
	);

	always #4 clk = ~clk;

	// watchdog
	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, core or bus stopped responding", cycles);
			$display("TEST FAIL");
			$finish;
		end
	end

	//////////////////////////////
	// bus and checks
	//////////////////////////////

	// setup, access, then idle; outputs sampled on the rising edge
	task automatic apbTransfer(input logic write, input cpuPkg::apbAddr_t addr,
			input cpuPkg::word_t wdata, output cpuPkg::word_t rdata, output logic err);
		@(negedge clk);
		pSel = 1'b1;
		pEnable = 1'b0;
		pWrite = write;
		pAddr = addr;
		pWData = wdata;
		@(negedge clk);
		pEnable = 1'b1;
		@(posedge clk);
		while (!pReady) begin
			@(posedge clk);
		end
		rdata = pRData;
		err = pSlvErr;
		@(negedge clk);
		pSel = 1'b0;
		pEnable = 1'b0;
	endtask

	task automatic apbWrite(input cpuPkg::apbAddr_t addr, input cpuPkg::word_t data,
			output logic err);
		cpuPkg::word_t unused;
		apbTransfer(1'b1, addr, data, unused, err);
	endtask

	task automatic apbRead(input cpuPkg::apbAddr_t addr, output cpuPkg::word_t data);
		logic err;
		apbTransfer(1'b0, addr, '0, data, err);
	endtask

	task automatic checkWord(input string name, input cpuPkg::word_t got,
			input cpuPkg::word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %s: got %h, expected %h", name, got, exp);
		end
	endtask

	//////////////////////////////
	// programs and model
	//////////////////////////////

	function automatic int randBelow(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic cpuPkg::word_t encR(input cpuPkg::funct_t fn,
			input cpuPkg::regIdx_t rs, input cpuPkg::regIdx_t rt, input cpuPkg::regIdx_t rd);
		return {cpuPkg::OP_RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic cpuPkg::word_t encI(input cpuPkg::opcode_t op,
			input cpuPkg::regIdx_t rs, input cpuPkg::regIdx_t rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// registers 1..7 only, so almost every instruction depends on a recent one
	task automatic genProgram();
		cpuPkg::funct_t fns [5] = '{cpuPkg::FN_ADD, cpuPkg::FN_SUB, cpuPkg::FN_AND,
			cpuPkg::FN_OR, cpuPkg::FN_SLT};
		cpuPkg::regIdx_t rs, rt, rd;
		int kind;
		logic lastBranch;
		lastBranch = 1'b0;
		for (int i = 0; i < PROG_LEN - 1; i++) begin
			rs = cpuPkg::regIdx_t'(1 + randBelow(7));
			rt = cpuPkg::regIdx_t'(1 + randBelow(7));
			rd = cpuPkg::regIdx_t'(1 + randBelow(7));
			kind = randBelow(20);
			// no branch in a delay slot, and the slot must sit before the halt
			if (kind >= 17 && (lastBranch || i > PROG_LEN - 4)) begin
				kind = 0;
			end
			lastBranch = 1'b0;
			if (kind < 8) begin
				prog[i] = encR(fns[kind % 5], rs, rt, rd);
			end else if (kind < 11) begin
				prog[i] = encI(cpuPkg::OP_ADDI, rs, rt, 16'(randBelow(65536)));
			end else if (kind < 14) begin
				prog[i] = encI(cpuPkg::OP_LW, '0, rt, 16'(randBelow(DATA_WORDS) * 4));
			end else if (kind < 17) begin
				prog[i] = encI(cpuPkg::OP_SW, '0, rt, 16'(randBelow(DATA_WORDS) * 4));
			end else begin
				// some always taken
				if (randBelow(4) == 0) begin
					rt = rs;
				end
				// offset from the delay slot, target lands at or before the halt
				prog[i] = encI(cpuPkg::OP_BEQ, rs, rt, 16'(1 + randBelow(PROG_LEN - 2 - i)));
				lastBranch = 1'b1;
			end
		end
		prog[PROG_LEN - 1] = {cpuPkg::OP_HALT, 26'd0};
	endtask

	// instruction-set model, npc carries the delay slot
	task automatic runModel();
		int pc, npc, nextNpc;
		cpuPkg::word_t ins, a, b, imm, res;
		cpuPkg::regIdx_t rs, rt, rd;
		pc = 0;
		npc = 1;
		modelCount = 0;
		while (modelCount < 4 * PROG_LEN) begin
			ins = prog[pc];
			rs = ins[25:21];
			rt = ins[20:16];
			rd = ins[15:11];
			a = modelRegs[rs];
			b = modelRegs[rt];
			imm = {{16{ins[15]}}, ins[15:0]};
			modelCount++;
			nextNpc = npc + 1;
			case (ins[31:26])
				cpuPkg::OP_HALT: return;
				cpuPkg::OP_RTYPE: begin
					case (ins[5:0])
						cpuPkg::FN_SUB: res = a - b;
						cpuPkg::FN_AND: res = a & b;
						cpuPkg::FN_OR: res = a | b;
						cpuPkg::FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: res = a + b;
					endcase
					modelRegs[rd] = res;
				end
				cpuPkg::OP_ADDI: modelRegs[rt] = a + imm;
				cpuPkg::OP_LW: begin
					res = a + imm;
					modelRegs[rt] = modelMem[res[9:2]];
				end
				cpuPkg::OP_SW: begin
					res = a + imm;
					modelMem[res[9:2]] = b;
				end
				cpuPkg::OP_BEQ: begin
					if (a == b) begin
						nextNpc = pc + 1 + int'($signed(ins[15:0]));
					end
				end
				default: ;
			endcase
			modelRegs[0] = '0;
			pc = npc;
			npc = nextNpc;
		end
	endtask

	// load, run to halt, then compare everything the host can see
	task automatic runProgram(input int num);
		cpuPkg::word_t data;
		logic err;
		int startErrors;
		startErrors = errors;
		genProgram();
		for (int w = 0; w < DATA_WORDS; w++) begin
			modelMem[w] = $random(seed);
			apbWrite(cpuPkg::DMEM_BASE + 12'(4 * w), modelMem[w], err);
		end
		for (int i = 0; i < PROG_LEN; i++) begin
			apbWrite(cpuPkg::IMEM_BASE + 12'(4 * i), prog[i], err);
		end
		runModel();
		apbWrite(cpuPkg::ADDR_CTRL, 32'd1, err);
		// program memory locked while running
		apbWrite(cpuPkg::IMEM_BASE, ~prog[0], err);
		checkBit("pSlvErr", err, 1'b1);
		data = '0;
		while (!data[0]) begin
			apbRead(cpuPkg::ADDR_STATUS, data);
		end
		apbRead(cpuPkg::ADDR_RETIRED, data);
		checkWord("retired", data, cpuPkg::word_t'(modelCount));
		apbWrite(cpuPkg::ADDR_CTRL, '0, err);
		apbRead(cpuPkg::ADDR_STATUS, data);
		checkBit("halted", data[0], 1'b1);
		for (int r = 0; r < 8; r++) begin
			apbRead(cpuPkg::REG_BASE + 12'(4 * r), data);
			checkWord($sformatf("r%0d", r), data, modelRegs[r]);
		end
		for (int w = 0; w < DATA_WORDS; w++) begin
			apbRead(cpuPkg::DMEM_BASE + 12'(4 * w), data);
			checkWord($sformatf("dmem[%0d]", w), data, modelMem[w]);
		end
		// rejected write left the program intact
		for (int i = 0; i < PROG_LEN; i++) begin
			apbRead(cpuPkg::IMEM_BASE + 12'(4 * i), data);
			checkWord($sformatf("imem[%0d]", i), data, prog[i]);
		end
		$display("program %0d: %0d retired, %0d errors", num, modelCount,
			errors - startErrors);
	endtask

	initial begin
		cpuPkg::word_t data;
		int startErrors;
		rstN = 1'b0;
		pSel = 1'b0;
		pEnable = 1'b0;
		pWrite = 1'b0;
		pAddr = '0;
		pWData = '0;
		for (int r = 0; r < 32; r++) begin
			modelRegs[r] = '0;
		end
		repeat (10) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;

		// state straight after reset
		startErrors = errors;
		apbRead(cpuPkg::ADDR_STATUS, data);
		checkBit("halted", data[0], 1'b0);
		apbRead(cpuPkg::ADDR_RETIRED, data);
		checkWord("retired", data, '0);
		apbRead(cpuPkg::ADDR_CTRL, data);
		checkBit("run", data[0], 1'b0);
		apbRead(cpuPkg::REG_BASE + 12'd20, data);
		checkWord("r5", data, '0);
		$display("reset: %0d errors", errors - startErrors);

		for (int p = 1; p <= NUM_PROGS; p++) begin
			runProgram(p);
		end

		$display("%0d tests, %0d checks, %0d errors", NUM_PROGS + 1, checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
